// ==== core_ctrl.f ====
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/hazard_pkg.sv
rtl/ctrl_fsm.sv
rtl/stall_unit.sv
rtl/fwd_unit.sv
rtl/core_ctrl.sv
test/tb_clk_gen.sv
test/ctrl_checker.sv
test/core_ctrl_tb.sv

// ==== rtl/core_ctrl.sv ====
/* core controller top
   joins the control fsm, the stall unit and the forwarding unit */
`timescale 1ns/10ps
`include "core_ctrl_params.svh"

module core_ctrl import ctrl_pkg::*, hazard_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   id_ready_i,
  input  logic                   ex_valid_i,
  input  logic                   branch_taken_ex_i,
  input  logic                   irq_wake_i,
  input  dec_flags_t             dec_i,
  input  irq_req_t               irq_req_i,
  input  logic                   data_req_ex_i,
  input  logic                   data_misaligned_i,
  input  logic                   mult_multicycle_i,
  input  logic [`REG_ADDR_W-1:0] id_waddr_i,
  input  rf_wr_stat_t            rf_stat_i,
  input  op_match_t              match_i,

  output logic                   instr_req_o,
  output logic                   pc_set_o,
  output pc_sel_e                pc_mux_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output logic                   busy_o,
  output logic                   irq_ack_o,
  output logic                   exc_ack_o,
  output logic                   csr_save_if_o,
  output logic                   csr_save_id_o,
  output logic                   csr_save_cause_o,
  output cause_u                 csr_cause_o,
  output logic                   csr_restore_mret_o,
  output logic                   deassert_we_o,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   misaligned_stall_o,
  output fwd_sel_e               fwd_a_o,
  output fwd_sel_e               fwd_b_o,
  output fwd_sel_e               fwd_c_o
);

  logic is_decoding;

  // second beat of a misaligned access holds id
  assign misaligned_stall_o = data_misaligned_i;

  ctrl_fsm u_ctrl_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .id_ready_i         (id_ready_i),
    .ex_valid_i         (ex_valid_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .irq_wake_i         (irq_wake_i),
    .dec_i              (dec_i),
    .irq_req_i          (irq_req_i),
    .jr_stall_i         (jr_stall_o),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .busy_o             (busy_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .csr_save_if_o      (csr_save_if_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_cause_o        (csr_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .is_decoding_o      (is_decoding)
  );

  // hazards on the instruction currently in id
  stall_unit u_stall_unit (
    .is_decoding_i (is_decoding),
    .dec_i         (dec_i),
    .data_req_ex_i (data_req_ex_i),
    .id_waddr_i    (id_waddr_i),
    .rf_stat_i     (rf_stat_i),
    .match_i       (match_i),
    .deassert_we_o (deassert_we_o),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o)
  );

  fwd_unit u_fwd_unit (
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .rf_stat_i         (rf_stat_i),
    .match_i           (match_i),
    .fwd_a_o           (fwd_a_o),
    .fwd_b_o           (fwd_b_o),
    .fwd_c_o           (fwd_c_o)
  );

endmodule

// ==== rtl/core_ctrl_params.svh ====
/* core controller width definitions
   register address, interrupt id, cause word and pc select widths */
`ifndef CORE_CTRL_PARAMS_SVH
`define CORE_CTRL_PARAMS_SVH

////////////////////
// register file
////////////////////

// 6 bit address so the fp registers fit in the same space
`define REG_ADDR_W 6

////////////////////
// traps
////////////////////

`define IRQ_ID_W 5
// interrupt id plus the top irq bit
`define CAUSE_W 6
`define PC_MUX_W 3

`endif

// ==== rtl/ctrl_fsm.sv ====
/* main controller fsm
   steers fetch, pipeline flushes, exceptions, mret and interrupt entry */
`timescale 1ns/10ps

module ctrl_fsm import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       branch_taken_ex_i,
  input  logic       irq_wake_i,
  input  dec_flags_t dec_i,
  input  irq_req_t   irq_req_i,
  input  logic       jr_stall_i,

  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       busy_o,
  output logic       irq_ack_o,
  output logic       exc_ack_o,
  output logic       csr_save_if_o,
  output logic       csr_save_id_o,
  output logic       csr_save_cause_o,
  output cause_u     csr_cause_o,
  output logic       csr_restore_mret_o,
  output logic       is_decoding_o
);

  ctrl_state_e state_q, state_d;
  logic        jump_done_q, jump_done_d;
  logic        irq_en;
  logic        jump_dec;

  // machine mode only, so m_ie alone gates the request
  assign irq_en   = irq_req_i.req & irq_req_i.m_ie;
  // jal and jalr both know their target in decode
  assign jump_dec = dec_i.jump | dec_i.jalr;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d            = state_q;
    jump_done_d        = jump_done_q;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;
    busy_o             = 1'b1;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_restore_mret_o = 1'b0;
    is_decoding_o      = 1'b0;

    unique case (state_q)
      // idle until fetch is enabled, boot pc held on the mux
      ST_RESET:
      begin
        instr_req_o = 1'b0;
        busy_o      = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i)
          state_d = ST_BOOT_SET;
      end

      // load the boot address and start fetching
      ST_BOOT_SET:
      begin
        pc_set_o = 1'b1;
        state_d  = ST_FIRST_FETCH;
      end

      ST_WAIT_SLEEP,
      ST_SLEEP:
      begin
        instr_req_o = 1'b0;
        busy_o      = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (state_q == ST_WAIT_SLEEP)
          state_d = ST_SLEEP;
        // any interrupt line wakes the core, enable or not
        else if (irq_wake_i)
          state_d = ST_FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      ST_FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = ST_DECODE;
        // pipeline is empty here, so the irq is taken straight from if
        if (irq_en)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = ST_IRQ_TAKEN_IF;
        end
      end

      ST_DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // id holds a wrong-path instruction, redirect only
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (irq_en)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ST_IRQ_FLUSH;
          end
          else if (jump_dec)
          begin
            pc_mux_o = PC_JUMP;
            // wait out a jr hazard, and redirect only once per jump
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (dec_i.pipe_flush)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ST_FLUSH_EX;
          end
          else if (dec_i.ecall || dec_i.illegal)
          begin
            halt_if_o               = 1'b1;
            halt_id_o               = 1'b1;
            csr_save_id_o           = 1'b1;
            csr_save_cause_o        = 1'b1;
            csr_cause_o.exc.is_irq  = 1'b0;
            csr_cause_o.exc.code    = dec_i.ecall ? EXC_ECALL_MMODE : EXC_ILLEGAL_INSN;
            state_d                 = ST_FLUSH_EX;
          end
          else if (dec_i.mret)
          begin
            halt_if_o          = 1'b1;
            halt_id_o          = 1'b1;
            csr_restore_mret_o = 1'b1;
            state_d            = ST_FLUSH_EX;
          end
          else if (dec_i.csr_status)
          begin
            // status write may change m_ie, drain before the next fetch
            halt_if_o = 1'b1;
            state_d   = id_ready_i ? ST_FLUSH_EX : ST_DECODE;
          end
        end
      end

      // let ex finish so csr state is settled
      ST_FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ST_FLUSH_WB;
      end

      // id still holds the flushing instruction, its strobes pick the target
      ST_FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (dec_i.ecall || dec_i.illegal)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_EXCEPTION;
        end
        else if (dec_i.mret)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_MRET;
        end
        // wfi parks the core, everything else resumes
        state_d = dec_i.pipe_flush ? ST_WAIT_SLEEP : ST_DECODE;
      end

      ST_IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = ST_IRQ_TAKEN_ID;
      end

      // save the epc from id or if, jump to the handler
      ST_IRQ_TAKEN_ID,
      ST_IRQ_TAKEN_IF:
      begin
        pc_set_o               = 1'b1;
        pc_mux_o               = PC_EXCEPTION;
        csr_save_cause_o       = 1'b1;
        csr_cause_o.irq.is_irq = 1'b1;
        csr_cause_o.irq.id     = irq_req_i.id;
        csr_save_id_o          = (state_q == ST_IRQ_TAKEN_ID);
        csr_save_if_o          = (state_q == ST_IRQ_TAKEN_IF);
        irq_ack_o              = 1'b1;
        exc_ack_o              = 1'b1;
        state_d                = ST_DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ST_RESET;
      end
    endcase
  end

  ////////////////////
  // state registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ST_RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // drop once the jump has left id
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  // no branch prediction, so ex cannot resolve two taken branches back to back
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branch in two consecutive cycles");

  // trap entry only from the flush and irq states, never straight from decode
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ST_DECODE) |-> !(pc_set_o && pc_mux_o == PC_EXCEPTION))
    else $error("exception pc set while in decode");

endmodule

// ==== rtl/ctrl_pkg.sv ====
/* controller types
   pc select, fsm states, trap cause word and decoder strobes */
`include "core_ctrl_params.svh"

package ctrl_pkg;

  // pc source steered into the fetch stage
  typedef enum logic [`PC_MUX_W-1:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4
  } pc_sel_e;

  // controller states, machine mode only
  typedef enum logic [3:0] {
    ST_RESET, ST_BOOT_SET, ST_WAIT_SLEEP, ST_SLEEP, ST_FIRST_FETCH,
    ST_DECODE, ST_IRQ_FLUSH, ST_IRQ_TAKEN_ID, ST_IRQ_TAKEN_IF,
    ST_FLUSH_EX, ST_FLUSH_WB
  } ctrl_state_e;

  // synchronous exception codes
  typedef enum logic [`CAUSE_W-2:0] {
    EXC_ILLEGAL_INSN = 5'd2,
    EXC_ECALL_MMODE  = 5'd11
  } exc_cause_e;

  typedef struct packed {
    logic                is_irq;
    logic [`IRQ_ID_W-1:0] id;
  } irq_cause_t;

  typedef struct packed {
    logic       is_irq;
    exc_cause_e code;
  } exc_cause_t;

  // one cause word, the top bit tells which view holds
  typedef union packed {
    irq_cause_t irq;
    exc_cause_t exc;
  } cause_u;

  // decoder strobes for the instruction in id
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic pipe_flush;
    logic csr_status;
    logic jump;
    logic jalr;
    logic cond_branch;
  } dec_flags_t;

  // pending interrupt from the interrupt controller
  typedef struct packed {
    logic                 req;
    logic [`IRQ_ID_W-1:0] id;
    logic                 m_ie;
  } irq_req_t;

endpackage

// ==== rtl/fwd_unit.sv ====
/* operand forwarding select
   picks regfile, ex or wb data for operands a, b and c */
`timescale 1ns/10ps

module fwd_unit import hazard_pkg::*;
(
  input  logic        data_misaligned_i,
  input  logic        mult_multicycle_i,
  input  rf_wr_stat_t rf_stat_i,
  input  op_match_t   match_i,

  output fwd_sel_e    fwd_a_o,
  output fwd_sel_e    fwd_b_o,
  output fwd_sel_e    fwd_c_o
);

  // alu forward is younger than wb, so it wins
  function automatic fwd_sel_e pick_src(input logic wb_hit, input logic alu_hit);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (rf_stat_i.we_wb && wb_hit)
      sel = SEL_FW_WB;
    if (rf_stat_i.alu_we_fw && alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  always_comb
  begin
    fwd_a_o = pick_src(match_i.wb.a, match_i.alu.a);
    fwd_b_o = pick_src(match_i.wb.b, match_i.alu.b);
    fwd_c_o = pick_src(match_i.wb.c, match_i.alu.c);

    // second half of a misaligned access reuses the ex address
    if (data_misaligned_i)
    begin
      fwd_a_o = SEL_FW_EX;
      fwd_b_o = SEL_REGFILE;
    end
    // multicycle mul keeps its partial result on operand c
    else if (mult_multicycle_i)
    begin
      fwd_c_o = SEL_FW_EX;
    end
  end

endmodule

// ==== rtl/hazard_pkg.sv ====
/* hazard types
   operand forwarding selects and register write status bundles */
`include "core_ctrl_params.svh"

package hazard_pkg;

  // operand source in the id stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // write status of the stages behind id
  typedef struct packed {
    logic                   we_ex;
    logic                   we_wb;
    logic                   alu_we_fw;
    logic [`REG_ADDR_W-1:0] ex_waddr;
    logic                   wb_ready;
  } rf_wr_stat_t;

  // one destination compared against operands a, b and c
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } op_hit_t;

  typedef struct packed {
    op_hit_t ex;
    op_hit_t wb;
    op_hit_t alu;
  } op_match_t;

endpackage

// ==== rtl/stall_unit.sv ====
/* stall detection
   load-use and jump-register hazards with write-enable suppression */
`timescale 1ns/10ps
`include "core_ctrl_params.svh"

module stall_unit import ctrl_pkg::*, hazard_pkg::*;
(
  input  logic                   is_decoding_i,
  input  dec_flags_t             dec_i,
  input  logic                   data_req_ex_i,
  input  logic [`REG_ADDR_W-1:0] id_waddr_i,
  input  rf_wr_stat_t            rf_stat_i,
  input  op_match_t              match_i,

  output logic                   deassert_we_o,
  output logic                   load_stall_o,
  output logic                   jr_stall_o
);

  logic load_pending;
  logic load_hit;
  logic jr_hit;

  // a load in ex, or a wb write that has not landed yet
  assign load_pending = (data_req_ex_i & rf_stat_i.we_ex) |
                        (~rf_stat_i.wb_ready & rf_stat_i.we_wb);

  // id reads the load target, or writes it and would race the load (waw)
  assign load_hit = match_i.ex.a | match_i.ex.b | match_i.ex.c |
                    (is_decoding_i & (rf_stat_i.ex_waddr == id_waddr_i));

  assign load_stall_o = load_pending & load_hit;

  // jalr target comes from operand a before forwarding muxes
  // so any pending writer to it must drain first
  assign jr_hit = (rf_stat_i.we_wb & match_i.wb.a) |
                  (rf_stat_i.we_ex & match_i.ex.a) |
                  (rf_stat_i.alu_we_fw & match_i.alu.a);

  assign jr_stall_o = dec_i.jalr & jr_hit;

  // keep the stalled or invalid instruction from writing back
  assign deassert_we_o = ~is_decoding_i | dec_i.illegal | load_stall_o | jr_stall_o;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f core_ctrl.f --top-module core_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vcore_ctrl_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" <<< "$out"; then
  exit 0
fi
exit 1

// ==== test/core_ctrl_tb.sv ====
/* core controller testbench
   seeded random stimulus on falling edges, model checks and a cycle timeout */
`timescale 1ns/10ps
`include "core_ctrl_params.svh"

module core_ctrl_tb import ctrl_pkg::*, hazard_pkg::*;
();

  localparam int N_CYCLES   = 3000;
  // stimulus plus margin for reset and boot
  localparam int MAX_CYCLES = N_CYCLES + 1000;

  logic                   clk;
  logic                   rst_n;
  logic                   fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i;
  logic                   branch_taken_ex_i, irq_wake_i, data_req_ex_i;
  logic                   data_misaligned_i, mult_multicycle_i;
  dec_flags_t             dec_i;
  irq_req_t               irq_req_i;
  logic [`REG_ADDR_W-1:0] id_waddr_i;
  rf_wr_stat_t            rf_stat_i;
  op_match_t              match_i;
  logic                   instr_req_o, pc_set_o, halt_if_o, halt_id_o, busy_o;
  logic                   irq_ack_o, exc_ack_o, csr_save_if_o, csr_save_id_o;
  logic                   csr_save_cause_o, csr_restore_mret_o;
  logic                   deassert_we_o, load_stall_o, jr_stall_o, misaligned_stall_o;
  pc_sel_e                pc_mux_o;
  cause_u                 csr_cause_o;
  fwd_sel_e               fwd_a_o, fwd_b_o, fwd_c_o;
  int                     cycle_cnt = 0;
  int                     n_fail;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_ctrl dut (.*);

  ctrl_checker u_checker (.*);

  task automatic drive_random(input logic booted);
    logic [31:0] r;
    logic [31:0] r2;
    r  = $urandom;
    r2 = $urandom;
    fetch_enable_i    = booted;
    instr_valid_i     = |r[1:0];
    id_ready_i        = |r[3:2];
    ex_valid_i        = r[4];
    // ex never resolves two taken branches back to back
    branch_taken_ex_i = !branch_taken_ex_i && (r[7:5] == 3'd0);
    irq_wake_i        = (r[9:8] == 2'd0);
    irq_req_i.req     = (r[12:10] == 3'd0);
    irq_req_i.id      = r[17:13];
    irq_req_i.m_ie    = |r[19:18];
    data_req_ex_i     = r[20];
    data_misaligned_i = (r[23:21] == 3'd0);
    mult_multicycle_i = (r[25:24] == 2'd0);
    rf_stat_i         = r2[9:0];
    match_i           = r2[18:10];
    // narrow address range so waw hits come up often
    rf_stat_i.ex_waddr = `REG_ADDR_W'(r2[20:19]);
    id_waddr_i         = `REG_ADDR_W'(r2[22:21]);
    // a halted id stage keeps its instruction
    if (!halt_id_o)
    begin
      if (r2[27])
        dec_i = dec_flags_t'(8'd1 << r2[26:24]);
      else
        dec_i = '0;
    end
  endtask

  initial
  begin
    fetch_enable_i    = 1'b0;
    instr_valid_i     = 1'b0;
    id_ready_i        = 1'b0;
    ex_valid_i        = 1'b0;
    branch_taken_ex_i = 1'b0;
    irq_wake_i        = 1'b0;
    data_req_ex_i     = 1'b0;
    data_misaligned_i = 1'b0;
    mult_multicycle_i = 1'b0;
    dec_i             = '0;
    irq_req_i         = '0;
    id_waddr_i        = '0;
    rf_stat_i         = '0;
    match_i           = '0;
    void'($urandom(32'hddd9b886));
    @(posedge rst_n);
    // a few idle cycles in reset state before fetch is enabled
    for (int i = 0; i < N_CYCLES; i++)
    begin
      @(negedge clk);
      drive_random(i >= 4);
    end
    @(negedge clk);
    u_checker.summarize(n_fail);
    if (n_fail == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

// ==== test/ctrl_checker.sv ====
/* controller checker
   cycle model of the fsm, stall and forwarding rules, compared on each rising edge */
`timescale 1ns/10ps
`include "core_ctrl_params.svh"

module ctrl_checker import ctrl_pkg::*, hazard_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  // stimulus seen by the dut
  input logic                   fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i,
  input logic                   branch_taken_ex_i, irq_wake_i, data_req_ex_i,
  input logic                   data_misaligned_i, mult_multicycle_i,
  input dec_flags_t             dec_i,
  input irq_req_t               irq_req_i,
  input logic [`REG_ADDR_W-1:0] id_waddr_i,
  input rf_wr_stat_t            rf_stat_i,
  input op_match_t              match_i,
  // dut responses
  input logic                   instr_req_o, pc_set_o, halt_if_o, halt_id_o, busy_o,
  input logic                   irq_ack_o, exc_ack_o, csr_save_if_o, csr_save_id_o,
  input logic                   csr_save_cause_o, csr_restore_mret_o,
  input logic                   deassert_we_o, load_stall_o, jr_stall_o, misaligned_stall_o,
  input pc_sel_e                pc_mux_o,
  input cause_u                 csr_cause_o,
  input fwd_sel_e               fwd_a_o, fwd_b_o, fwd_c_o
);

  typedef enum int {
    M_RESET, M_BOOT_SET, M_WAIT_SLEEP, M_SLEEP, M_FIRST_FETCH, M_DECODE,
    M_IRQ_FLUSH, M_IRQ_ID, M_IRQ_IF, M_FLUSH_EX, M_FLUSH_WB
  } model_state_e;

  // expected fsm outputs for one cycle
  typedef struct packed {
    logic       req;
    logic       set;
    logic [2:0] mux;
    logic       halt_if;
    logic       halt_id;
    logic       busy;
    logic       ack;
    logic       save_if;
    logic       save_id;
    logic       save_cause;
    logic [5:0] cause;
    logic       mret;
  } fsm_out_t;

  model_state_e st = M_RESET;
  model_state_e st_nx;
  logic         jdone = 1'b0;
  logic         jdone_nx;
  fsm_out_t     exp_o;
  logic         exp_dec, exp_load, exp_jr, exp_dwe;
  fwd_sel_e     exp_fa, exp_fb, exp_fc;
  // fsm, stall and forwarding mismatches
  int           err_cnt [3];
  // irq from id, irq from if, exception, mret, wake from sleep
  int           seen [5];

  task automatic check_eq(input int grp, input string name,
                          input logic [7:0] expv, input logic [7:0] actv);
    if (expv !== actv)
    begin
      $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, expv, actv);
      err_cnt[grp] += 1;
    end
  endtask

  // youngest writer wins, then wb, then the register file
  function automatic fwd_sel_e expected_src(input logic wb_hit, input logic alu_hit);
    if (rf_stat_i.alu_we_fw && alu_hit)
      return SEL_FW_EX;
    if (rf_stat_i.we_wb && wb_hit)
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  ////////////////////
  // stall and forwarding model
  ////////////////////

  task automatic predict_hazards();
    logic pending;
    logic hit;
    exp_dec  = (st == M_DECODE) && !branch_taken_ex_i && instr_valid_i;
    pending  = (data_req_ex_i && rf_stat_i.we_ex) || (rf_stat_i.we_wb && !rf_stat_i.wb_ready);
    hit      = (|match_i.ex) || (exp_dec && (rf_stat_i.ex_waddr == id_waddr_i));
    exp_load = pending && hit;
    exp_jr   = dec_i.jalr && ((match_i.ex.a && rf_stat_i.we_ex) ||
                              (match_i.wb.a && rf_stat_i.we_wb) ||
                              (match_i.alu.a && rf_stat_i.alu_we_fw));
    exp_dwe  = !exp_dec || dec_i.illegal || exp_load || exp_jr;
    exp_fa   = expected_src(match_i.wb.a, match_i.alu.a);
    exp_fb   = expected_src(match_i.wb.b, match_i.alu.b);
    exp_fc   = expected_src(match_i.wb.c, match_i.alu.c);
    if (data_misaligned_i)
    begin
      exp_fa = SEL_FW_EX;
      exp_fb = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
      exp_fc = SEL_FW_EX;
  endtask

  ////////////////////
  // fsm model
  ////////////////////

  task automatic predict_fsm();
    logic irq_on;
    irq_on     = irq_req_i.req && irq_req_i.m_ie;
    exp_o      = '0;
    exp_o.req  = 1'b1;
    exp_o.busy = 1'b1;
    st_nx      = st;
    jdone_nx   = jdone;
    case (st)
      M_RESET:
      begin
        exp_o.req  = 1'b0;
        exp_o.busy = 1'b0;
        exp_o.set  = 1'b1;
        if (fetch_enable_i)
          st_nx = M_BOOT_SET;
      end
      M_BOOT_SET:
      begin
        exp_o.set = 1'b1;
        st_nx     = M_FIRST_FETCH;
      end
      M_WAIT_SLEEP,
      M_SLEEP:
      begin
        exp_o.req                       = 1'b0;
        exp_o.busy                      = 1'b0;
        {exp_o.halt_if, exp_o.halt_id}  = 2'b11;
        if (st == M_WAIT_SLEEP)
          st_nx = M_SLEEP;
        else if (irq_wake_i)
          st_nx = M_FIRST_FETCH;
      end
      M_FIRST_FETCH:
      begin
        if (id_ready_i)
          st_nx = M_DECODE;
        if (irq_on)
        begin
          {exp_o.halt_if, exp_o.halt_id} = 2'b11;
          st_nx = M_IRQ_IF;
        end
      end
      M_DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          exp_o.set = 1'b1;
          exp_o.mux = PC_BRANCH;
        end
        else if (instr_valid_i && irq_on)
        begin
          {exp_o.halt_if, exp_o.halt_id} = 2'b11;
          st_nx = M_IRQ_FLUSH;
        end
        else if (instr_valid_i && (dec_i.jump || dec_i.jalr))
        begin
          exp_o.set = !exp_jr && !jdone;
          exp_o.mux = PC_JUMP;
          if (exp_o.set)
            jdone_nx = 1'b1;
        end
        else if (instr_valid_i && (dec_i.pipe_flush || dec_i.ecall ||
                                   dec_i.illegal || dec_i.mret))
        begin
          {exp_o.halt_if, exp_o.halt_id} = 2'b11;
          st_nx = M_FLUSH_EX;
          if (!dec_i.pipe_flush && (dec_i.ecall || dec_i.illegal))
          begin
            exp_o.save_id    = 1'b1;
            exp_o.save_cause = 1'b1;
            exp_o.cause      = {1'b0, dec_i.ecall ? 5'd11 : 5'd2};
          end
          else if (!dec_i.pipe_flush)
            exp_o.mret = 1'b1;
        end
        else if (instr_valid_i && dec_i.csr_status)
        begin
          exp_o.halt_if = 1'b1;
          if (id_ready_i)
            st_nx = M_FLUSH_EX;
        end
      end
      M_FLUSH_EX:
      begin
        {exp_o.halt_if, exp_o.halt_id} = 2'b11;
        if (ex_valid_i)
          st_nx = M_FLUSH_WB;
      end
      M_FLUSH_WB:
      begin
        {exp_o.halt_if, exp_o.halt_id} = 2'b11;
        exp_o.set = dec_i.ecall || dec_i.illegal || dec_i.mret;
        exp_o.mux = (dec_i.ecall || dec_i.illegal) ? PC_EXCEPTION : PC_MRET;
        st_nx     = dec_i.pipe_flush ? M_WAIT_SLEEP : M_DECODE;
      end
      M_IRQ_FLUSH:
      begin
        {exp_o.halt_if, exp_o.halt_id} = 2'b11;
        st_nx = M_IRQ_ID;
      end
      M_IRQ_ID,
      M_IRQ_IF:
      begin
        exp_o.set        = 1'b1;
        exp_o.mux        = PC_EXCEPTION;
        exp_o.ack        = 1'b1;
        exp_o.save_cause = 1'b1;
        exp_o.cause      = {1'b1, irq_req_i.id};
        exp_o.save_id    = (st == M_IRQ_ID);
        exp_o.save_if    = (st == M_IRQ_IF);
        st_nx            = M_DECODE;
      end
      default:
        st_nx = M_RESET;
    endcase
  endtask

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      st    <= M_RESET;
      jdone <= 1'b0;
    end
    else
    begin
      predict_hazards();
      predict_fsm();
      check_eq(0, "instr_req_o", 8'(exp_o.req), 8'(instr_req_o));
      check_eq(0, "pc_set_o", 8'(exp_o.set), 8'(pc_set_o));
      // the select only matters with pc_set_o
      if (exp_o.set)
        check_eq(0, "pc_mux_o", 8'(exp_o.mux), 8'(pc_mux_o));
      check_eq(0, "halt_if_o", 8'(exp_o.halt_if), 8'(halt_if_o));
      check_eq(0, "halt_id_o", 8'(exp_o.halt_id), 8'(halt_id_o));
      check_eq(0, "busy_o", 8'(exp_o.busy), 8'(busy_o));
      check_eq(0, "irq_ack_o", 8'(exp_o.ack), 8'(irq_ack_o));
      check_eq(0, "exc_ack_o", 8'(exp_o.ack), 8'(exc_ack_o));
      check_eq(0, "csr_save_if_o", 8'(exp_o.save_if), 8'(csr_save_if_o));
      check_eq(0, "csr_save_id_o", 8'(exp_o.save_id), 8'(csr_save_id_o));
      check_eq(0, "csr_save_cause_o", 8'(exp_o.save_cause), 8'(csr_save_cause_o));
      if (exp_o.save_cause)
        check_eq(0, "csr_cause_o", 8'(exp_o.cause), 8'(csr_cause_o));
      check_eq(0, "csr_restore_mret_o", 8'(exp_o.mret), 8'(csr_restore_mret_o));
      check_eq(1, "load_stall_o", 8'(exp_load), 8'(load_stall_o));
      check_eq(1, "jr_stall_o", 8'(exp_jr), 8'(jr_stall_o));
      check_eq(1, "deassert_we_o", 8'(exp_dwe), 8'(deassert_we_o));
      check_eq(1, "misaligned_stall_o", 8'(data_misaligned_i), 8'(misaligned_stall_o));
      check_eq(2, "fwd_a_o", 8'(exp_fa), 8'(fwd_a_o));
      check_eq(2, "fwd_b_o", 8'(exp_fb), 8'(fwd_b_o));
      check_eq(2, "fwd_c_o", 8'(exp_fc), 8'(fwd_c_o));
      // event tally from the model
      if (st == M_IRQ_ID)
        seen[0] += 1;
      if (st == M_IRQ_IF)
        seen[1] += 1;
      if (exp_o.save_cause && !exp_o.cause[5])
        seen[2] += 1;
      if (exp_o.mret)
        seen[3] += 1;
      if (st == M_SLEEP && st_nx == M_FIRST_FETCH)
        seen[4] += 1;
      st    <= st_nx;
      // jump_done lasts until id accepts the next instruction
      jdone <= jdone_nx & ~id_ready_i;
    end
  end

  task automatic summarize(output int n_fail);
    string what [5];
    int    missing;
    what[0] = "interrupt entry from decode";
    what[1] = "interrupt entry from first fetch";
    what[2] = "synchronous exception";
    what[3] = "mret return";
    what[4] = "wake-up from sleep";
    missing = 0;
    for (int k = 0; k < 5; k++)
    begin
      if (seen[k] == 0)
      begin
        $display("no %s happened during the run", what[k]);
        missing += 1;
      end
    end
    n_fail = err_cnt[0] + err_cnt[1] + err_cnt[2] + missing;
    $display("errors: fsm %0d, stall %0d, forwarding %0d, missing events %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], missing);
  endtask

endmodule

// ==== test/tb_clk_gen.sv ====
/* testbench clock and reset
   8 ns clock, reset low for the first 3 cycles */
`timescale 1ns/10ps

module tb_clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  logic clk = 1'b0;
  logic rst_n = 1'b0;

  always #4 clk = ~clk;

  initial
  begin
    repeat (3) @(posedge clk);
    // release between sampling edges
    @(negedge clk);
    rst_n = 1'b1;
  end

  assign clk_o   = clk;
  assign rst_n_o = rst_n;

endmodule
